// File: hdl/dma_pkg.sv
package dma_pkg;

	// cpu register addresses, word offsets in the dma window
	localparam logic [2:0] addr_ctrl     = 3'd2;
	localparam logic [2:0] addr_status   = 3'd3;
	localparam logic [2:0] addr_base_hi  = 3'd4;
	localparam logic [2:0] addr_base_mid = 3'd5;
	localparam logic [2:0] addr_base_lo  = 3'd6;

	// mode register fields
	localparam int mode_reg_lo = 1;
	localparam int mode_reg_hi = 2;
	localparam int mode_acsi   = 3;
	localparam int mode_scnt   = 4;

	// floppy register select, mode bits 2:1
	localparam logic [1:0] fdc_reg_cmd    = 2'b00;
	localparam logic [1:0] fdc_reg_track  = 2'b01;
	localparam logic [1:0] fdc_reg_sector = 2'b10;
	localparam logic [1:0] fdc_reg_data   = 2'b11;

	// type I and IV opcodes, upper nibble, update flag set
	localparam logic [3:0] cmd_restore   = 4'b0000;
	localparam logic [3:0] cmd_seek      = 4'b0001;
	localparam logic [3:0] cmd_step      = 4'b0011;
	localparam logic [3:0] cmd_step_in   = 4'b0101;
	localparam logic [3:0] cmd_step_out  = 4'b0111;
	localparam logic [3:0] cmd_force_int = 4'b1101;
	// type II opcodes, upper three bits
	localparam logic [2:0] cmd_rd_sec = 3'b100;
	localparam logic [2:0] cmd_wr_sec = 3'b101;

	// motor timer reload on real hardware
	localparam int motor_ticks_hw = 65535;

	// decoded write to the controller access register
	typedef struct packed {
		logic       valid;
		logic       acsi;
		logic [1:0] fdc_reg;
		logic       first;
		logic [7:0] data;
	} cpu_wr_t;

	typedef struct packed {
		logic [7:0] cmd;
		logic [7:0] track;
		logic [7:0] sector;
		logic [7:0] data;
		logic [1:0] busy;
		logic       motor;
		logic [7:0] status;
	} fdc_state_t;

	typedef struct packed {
		logic [2:0]      target;
		logic [4:0]      cmd;
		logic [4:0][7:0] parms;
		logic            busy;
	} acsi_state_t;

endpackage

// File: hdl/dma_regs.sv
`timescale 1ns/1ps

module dma_regs import dma_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] din,
	input  logic        sel,
	input  logic [2:0]  addr,
	input  logic        lds,
	input  logic        rw,
	input  fdc_state_t  fdc,
	input  acsi_state_t acsi,
	input  logic        fdc_br_req,
	input  logic        acsi_br_req,
	input  logic        ack_pulse,
	output logic [15:0] dout,
	output logic        br,
	output cpu_wr_t     wr,
	output logic        fdc_status_rd,
	output logic        acsi_status_rd,
	output logic [23:0] base,
	output logic [7:0]  scnt
);

	logic [15:0] mode;
	logic        byte_wr;
	logic        ctrl_win;
	logic [15:0] dma_status;

	// low byte strobe qualifies every byte register
	assign byte_wr = sel && !rw && !lds;
	// controller window, sector count takes it over when mode bit 4 set
	assign ctrl_win = (addr == addr_ctrl) && !mode[mode_scnt];

	// one decoded write for both controllers
	always_comb begin
		wr.valid   = byte_wr && ctrl_win;
		wr.acsi    = mode[mode_acsi];
		wr.fdc_reg = mode[mode_reg_hi:mode_reg_lo];
		wr.first   = !mode[mode_reg_lo];
		wr.data    = din[7:0];
	end

	// floppy status read clears the fdc interrupt
	assign fdc_status_rd = sel && rw && ctrl_win && !mode[mode_acsi] &&
		(mode[mode_reg_hi:mode_reg_lo] == fdc_reg_cmd);
	// acsi side, any read in acsi mode
	assign acsi_status_rd = sel && rw && !mode[mode_scnt] && mode[mode_acsi];

	// bit 0 is dma ok, bit 1 sectors pending
	assign dma_status = {14'd0, scnt != 8'd0, 1'b1};

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= '0;
			base <= '0;
			scnt <= '0;
			br   <= 1'b0;
		end else begin
			// io controller done, release bus
			if (ack_pulse) begin
				br   <= 1'b0;
				scnt <= '0;
			end
			// request from either controller
			if (fdc_br_req || acsi_br_req)
				br <= 1'b1;
			// mode takes the whole word
			if (sel && !rw && (addr == addr_status))
				mode <= din;
			if (byte_wr) begin
				case (addr)
					addr_ctrl: begin
						if (mode[mode_scnt])
							scnt <= din[7:0];
					end
					addr_base_hi:  base[23:16] <= din[7:0];
					addr_base_mid: base[15:8]  <= din[7:0];
					addr_base_lo:  base[7:0]   <= din[7:0];
					default: begin
					end
				endcase
			end
		end
	end

	// read back mux
	always_comb begin
		dout = '0;
		if (sel && rw) begin
			case (addr)
				addr_ctrl: begin
					if (mode[mode_scnt]) begin
						dout = {8'h00, scnt};
					end else if (mode[mode_acsi]) begin
						// target echo, status ok
						dout = {8'h00, acsi.target, 5'h00};
					end else begin
						case (mode[mode_reg_hi:mode_reg_lo])
							fdc_reg_cmd:    dout = {8'h00, fdc.status};
							fdc_reg_track:  dout = {8'h00, fdc.track};
							fdc_reg_sector: dout = {8'h00, fdc.sector};
							default:        dout = {8'h00, fdc.data};
						endcase
					end
				end
				addr_status:   dout = dma_status;
				addr_base_hi:  dout = {8'h00, base[23:16]};
				addr_base_mid: dout = {8'h00, base[15:8]};
				addr_base_lo:  dout = {8'h00, base[7:0]};
				default:       dout = '0;
			endcase
		end
	end

endmodule

// File: hdl/fdc_emu.sv
`timescale 1ns/1ps

module fdc_emu import dma_pkg::*; #(
	parameter int motor_ticks = motor_ticks_hw
) (
	input  logic       clk,
	input  logic       reset,
	input  cpu_wr_t    wr,
	input  logic       fdc_wr_prot,
	input  logic       fdc_status_rd,
	input  logic       ack_pulse,
	output fdc_state_t fdc,
	output logic       fdc_irq,
	output logic       fdc_br_req
);

	localparam int motor_w = $clog2(motor_ticks + 1);

	logic [7:0]         cmd;
	logic [7:0]         track;
	logic [7:0]         sector;
	logic [7:0]         data;
	// 3 waits for io controller, 2 and 1 count down
	logic [1:0]         busy;
	logic [motor_w-1:0] motor_cnt;
	logic               step_dir;
	logic               cmd_wr;
	logic               reg_wr;
	logic               motor_run;
	logic               track0;

	assign reg_wr = wr.valid && !wr.acsi;
	assign cmd_wr = reg_wr && (wr.fdc_reg == fdc_reg_cmd);

	// read sector always, write sector only on an unprotected disk
	assign fdc_br_req = cmd_wr && ((wr.data[7:5] == cmd_rd_sec) ||
		((wr.data[7:5] == cmd_wr_sec) && !fdc_wr_prot));

	assign motor_run = motor_cnt != '0;
	assign track0 = track == 8'd0;

	always_comb begin
		fdc.cmd    = cmd;
		fdc.track  = track;
		fdc.sector = sector;
		fdc.data   = data;
		fdc.busy   = busy;
		fdc.motor  = motor_run;
		// track 0 flag only valid for type I
		fdc.status = {motor_run, fdc_wr_prot, 3'b000,
			!cmd[7] && track0, 1'b0, busy != 2'd0};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd       <= '0;
			track     <= '0;
			sector    <= '0;
			data      <= '0;
			busy      <= '0;
			motor_cnt <= '0;
			step_dir  <= 1'b0;
			fdc_irq   <= 1'b0;
		end else begin
			// transfer acknowledged, skip to end of busy phase
			if (ack_pulse && (busy == 2'd3))
				busy <= 2'd1;
			// countdown, held while waiting at 3
			if ((busy != 2'd0) && (busy != 2'd3))
				busy <= busy - 2'd1;
			if (busy == 2'd1)
				fdc_irq <= 1'b1;
			if (fdc_status_rd)
				fdc_irq <= 1'b0;
			if (motor_run)
				motor_cnt <= motor_cnt - 1'b1;

			if (cmd_wr) begin
				cmd  <= wr.data;
				busy <= 2'd2;
				// type I and II spin up the motor
				if (!wr.data[7] || (wr.data[7:6] == 2'b10))
					motor_cnt <= motor_w'(motor_ticks);
				case (wr.data[7:4])
					cmd_restore: track <= 8'd0;
					cmd_seek:    track <= data;
					cmd_step:    track <= step_dir ? track + 8'd1 : track - 8'd1;
					cmd_step_in: begin
						step_dir <= 1'b1;
						track    <= track + 8'd1;
					end
					cmd_step_out: begin
						step_dir <= 1'b0;
						track    <= track - 8'd1;
					end
					cmd_force_int: busy <= 2'd1;
					default: begin
					end
				endcase
				// sector transfer waits for the io controller
				if (fdc_br_req)
					busy <= 2'd3;
			end else if (reg_wr) begin
				case (wr.fdc_reg)
					fdc_reg_track:  track  <= wr.data;
					fdc_reg_sector: sector <= wr.data;
					default:        data   <= wr.data;
				endcase
			end
		end
	end

endmodule

// File: hdl/acsi_cmd.sv
`timescale 1ns/1ps

module acsi_cmd import dma_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  cpu_wr_t     wr,
	input  logic [7:0]  acsi_enable,
	input  logic        acsi_status_rd,
	input  logic        ack_pulse,
	output acsi_state_t acsi,
	output logic        acsi_irq,
	output logic        acsi_br_req
);

	logic [2:0]      target;
	logic [4:0]      cmd;
	logic [4:0][7:0] parms;
	// next parameter slot
	logic [2:0]      idx;
	logic            busy;
	logic            byte_wr;
	logic            next_ok;

	assign byte_wr = wr.valid && wr.acsi;
	// parameter byte to an enabled target
	assign next_ok = byte_wr && !wr.first && acsi_enable[target];

	// fifth parameter hands over to the io controller
	assign acsi_br_req = next_ok && (idx == 3'd4);

	always_comb begin
		acsi.target = target;
		acsi.cmd    = cmd;
		acsi.parms  = parms;
		acsi.busy   = busy;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			target   <= '0;
			cmd      <= '0;
			parms    <= '0;
			idx      <= '0;
			busy     <= 1'b0;
			acsi_irq <= 1'b0;
		end else begin
			// io controller finished the command
			if (ack_pulse && busy) begin
				busy     <= 1'b0;
				acsi_irq <= 1'b1;
			end
			if (acsi_status_rd)
				acsi_irq <= 1'b0;

			if (byte_wr && wr.first) begin
				// target in 7:5, opcode in 4:0
				target <= wr.data[7:5];
				cmd    <= wr.data[4:0];
				idx    <= 3'd0;
				if (acsi_enable[wr.data[7:5]])
					acsi_irq <= 1'b1;
			end else if (byte_wr && (idx < 3'd5)) begin
				parms[idx] <= wr.data;
				idx        <= idx + 3'd1;
				// auto ack until the last byte
				if (next_ok && (idx < 3'd4))
					acsi_irq <= 1'b1;
				if (acsi_br_req)
					busy <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/io_status.sv
`timescale 1ns/1ps

module io_status import dma_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        dio_ack,
	input  logic [4:0]  dio_idx,
	input  logic [23:0] base,
	input  logic [7:0]  scnt,
	input  fdc_state_t  fdc,
	input  acsi_state_t acsi,
	input  logic        drv_side,
	input  logic [1:0]  drv_sel,
	output logic [7:0]  dio_data,
	output logic        ack_pulse
);

	logic ack_d1;
	logic ack_d2;

	// ack comes from another clock domain
	always_ff @(posedge clk) begin
		if (reset) begin
			ack_d1    <= 1'b0;
			ack_d2    <= 1'b0;
			ack_pulse <= 1'b0;
		end else begin
			ack_d1    <= dio_ack;
			ack_d2    <= ack_d1;
			// rising edge only, level may stay high
			ack_pulse <= ack_d1 && !ack_d2;
		end
	end

	// indexed status bytes
	always_comb begin
		case (dio_idx)
			5'd0:    dio_data = base[23:16];
			5'd1:    dio_data = base[15:8];
			5'd2:    dio_data = base[7:0];
			5'd3:    dio_data = scnt;
			5'd4:    dio_data = fdc.cmd;
			5'd5:    dio_data = fdc.track;
			5'd6:    dio_data = fdc.sector;
			5'd7:    dio_data = fdc.data;
			// drive and busy summary
			5'd8:    dio_data = {3'b000, acsi.busy, drv_sel, drv_side, fdc.busy != 2'd0};
			5'd9:    dio_data = {acsi.target, acsi.cmd};
			5'd10:   dio_data = acsi.parms[0];
			5'd11:   dio_data = acsi.parms[1];
			5'd12:   dio_data = acsi.parms[2];
			5'd13:   dio_data = acsi.parms[3];
			5'd14:   dio_data = acsi.parms[4];
			default: dio_data = 8'h00;
		endcase
	end

endmodule

// File: hdl/dma_top.sv
`timescale 1ns/1ps

module dma_top import dma_pkg::*; #(
	parameter int motor_ticks = motor_ticks_hw
) (
	input  logic        clk,
	input  logic        reset,
	// cpu bus, upper byte strobe is not decoded by any register
	input  logic [15:0] din,
	input  logic        sel,
	input  logic [2:0]  addr,
	input  logic        uds,
	input  logic        lds,
	input  logic        rw,
	output logic [15:0] dout,
	// to interrupt controller and bus arbiter
	output logic        irq,
	output logic        br,
	// system config
	input  logic        fdc_wr_prot,
	input  logic [7:0]  acsi_enable,
	// io controller status port
	input  logic [4:0]  dio_idx,
	output logic [7:0]  dio_data,
	input  logic        dio_ack,
	// from the sound chip port
	input  logic        drv_side,
	input  logic [1:0]  drv_sel
);

	cpu_wr_t     wr;
	fdc_state_t  fdc;
	acsi_state_t acsi;
	logic        fdc_status_rd;
	logic        acsi_status_rd;
	logic        fdc_br_req;
	logic        acsi_br_req;
	logic        fdc_irq;
	logic        acsi_irq;
	logic        ack_pulse;
	logic [23:0] base;
	logic [7:0]  scnt;

	dma_regs u_regs (
		.clk(clk), .reset(reset), .din(din), .sel(sel), .addr(addr),
		.lds(lds), .rw(rw), .fdc(fdc), .acsi(acsi),
		.fdc_br_req(fdc_br_req), .acsi_br_req(acsi_br_req), .ack_pulse(ack_pulse),
		.dout(dout), .br(br), .wr(wr), .fdc_status_rd(fdc_status_rd),
		.acsi_status_rd(acsi_status_rd), .base(base), .scnt(scnt)
	);

	fdc_emu #(.motor_ticks(motor_ticks)) u_fdc (
		.clk(clk), .reset(reset), .wr(wr), .fdc_wr_prot(fdc_wr_prot),
		.fdc_status_rd(fdc_status_rd), .ack_pulse(ack_pulse),
		.fdc(fdc), .fdc_irq(fdc_irq), .fdc_br_req(fdc_br_req)
	);

	acsi_cmd u_acsi (
		.clk(clk), .reset(reset), .wr(wr), .acsi_enable(acsi_enable),
		.acsi_status_rd(acsi_status_rd), .ack_pulse(ack_pulse),
		.acsi(acsi), .acsi_irq(acsi_irq), .acsi_br_req(acsi_br_req)
	);

	io_status u_io (
		.clk(clk), .reset(reset), .dio_ack(dio_ack), .dio_idx(dio_idx),
		.base(base), .scnt(scnt), .fdc(fdc), .acsi(acsi),
		.drv_side(drv_side), .drv_sel(drv_sel),
		.dio_data(dio_data), .ack_pulse(ack_pulse)
	);

	// one interrupt line for both controllers
	assign irq = fdc_irq || acsi_irq;

endmodule

// File: tb/tb_dma.sv
`timescale 1ns/1ps

module tb_dma import dma_pkg::*; ();

	// mode register words, bits 2:1 floppy select, bit 3 acsi, bit 4 sector count
	localparam logic [15:0] mode_fdc_cmd    = 16'h0000;
	localparam logic [15:0] mode_track      = 16'h0002;
	localparam logic [15:0] mode_sector     = 16'h0004;
	localparam logic [15:0] mode_data       = 16'h0006;
	localparam logic [15:0] mode_acsi_first = 16'h0008;
	localparam logic [15:0] mode_acsi_parm  = 16'h000A;
	localparam logic [15:0] mode_scnt_sel   = 16'h0010;

	// all tests take about 400 cycles with worst case ack delays
	localparam int test_cycles     = 400;
	localparam int watchdog_cycles = 10 * test_cycles;

	logic        clk = 1'b0;
	logic        reset;
	logic [15:0] din;
	logic        sel;
	logic [2:0]  addr;
	logic        uds;
	logic        lds;
	logic        rw;
	logic [15:0] dout;
	logic        irq;
	logic        br;
	logic        fdc_wr_prot;
	logic [7:0]  acsi_enable;
	logic [4:0]  dio_idx;
	logic [7:0]  dio_data;
	logic        dio_ack;
	logic        drv_side;
	logic [1:0]  drv_sel;

	int          checks = 0;
	int          errors = 0;
	int          prop_errors = 0;
	integer      seed = 45;
	logic        wp_phase = 1'b0;
	logic        off_target_phase = 1'b0;
	logic [15:0] rd;
	logic [7:0]  parm_bytes [0:4];

	dma_top #(.motor_ticks(40)) dut (
		.clk(clk), .reset(reset), .din(din), .sel(sel), .addr(addr),
		.uds(uds), .lds(lds), .rw(rw), .dout(dout), .irq(irq), .br(br),
		.fdc_wr_prot(fdc_wr_prot), .acsi_enable(acsi_enable),
		.dio_idx(dio_idx), .dio_data(dio_data), .dio_ack(dio_ack),
		.drv_side(drv_side), .drv_sel(drv_sel)
	);

	always #5 clk = ~clk;

	// protected disk never requests the bus
	assert property (@(posedge clk) disable iff (reset) wp_phase |-> !br)
		else begin
			prop_errors++;
			$display("error at %0d ns: br raised for a write-protected disk", $time);
		end

	// disabled target stays silent
	assert property (@(posedge clk) disable iff (reset) off_target_phase |-> !irq)
		else begin
			prop_errors++;
			$display("error at %0d ns: irq from a disabled acsi target", $time);
		end

	task automatic expect_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
		checks++;
		assert (got === exp)
			else begin
				errors++;
				$display("error at %0d ns: %s, got %h expected %h", $time, what, got, exp);
			end
	endtask

	task automatic expect_bit(input logic got, input logic exp, input string what);
		checks++;
		assert (got === exp)
			else begin
				errors++;
				$display("error at %0d ns: %s, got %b expected %b", $time, what, got, exp);
			end
	endtask

	// write edge is the second edge, returns 1 ns after it
	task automatic bus_write(input logic [2:0] a, input logic [15:0] d);
		@(posedge clk);
		#1;
		sel = 1'b1;
		rw = 1'b0;
		lds = 1'b0;
		addr = a;
		din = d;
		@(posedge clk);
		#1;
		sel = 1'b0;
		rw = 1'b1;
		lds = 1'b1;
	endtask

	// dout sampled mid cycle, the following edge is the read edge
	task automatic bus_read(input logic [2:0] a, output logic [15:0] d);
		@(posedge clk);
		#1;
		sel = 1'b1;
		rw = 1'b1;
		lds = 1'b0;
		addr = a;
		#2;
		d = dout;
		@(posedge clk);
		#1;
		sel = 1'b0;
		lds = 1'b1;
	endtask

	task automatic write_reg(input logic [15:0] mode, input logic [7:0] value);
		bus_write(addr_status, mode);
		bus_write(addr_ctrl, {8'h00, value});
	endtask

	task automatic check_dio(input logic [4:0] idx, input logic [7:0] exp, input string what);
		@(posedge clk);
		#1;
		dio_idx = idx;
		#1;
		expect_eq({8'h00, dio_data}, {8'h00, exp}, what);
	endtask

	// irq low for n samples after the write edge, then high
	task automatic expect_irq_after(input int n, input string what);
		int i;
		for (i = 0; i < n; i++) begin
			expect_bit(irq, 1'b0, what);
			@(posedge clk);
			#1;
		end
		expect_bit(irq, 1'b1, what);
	endtask

	// returns on the first edge that samples dio_ack high
	task automatic wait_ack(input int max, input string what);
		int n;
		n = 0;
		@(posedge clk);
		while (!dio_ack && n < max) begin
			@(posedge clk);
			n++;
		end
		if (!dio_ack) begin
			errors++;
			$display("timeout: the I/O controller never acknowledged the %s", what);
		end
	endtask

	task automatic type1_command(input logic [7:0] cmd, input logic [7:0] trk, input string what);
		logic [15:0] st;
		bus_write(addr_ctrl, {8'h00, cmd});
		expect_irq_after(2, what);
		bus_read(addr_ctrl, st);
		// motor on, track zero flag, not busy
		expect_eq(st, {8'h00, 1'b1, 4'b0000, trk == 8'd0, 2'b00}, what);
		expect_bit(irq, 1'b0, what);
		check_dio(5'd5, trk, what);
	endtask

	// I/O controller, acknowledges each request after a random delay
	initial begin : io_ctrl_model
		int delay;
		dio_ack = 1'b0;
		forever begin
			wait (br === 1'b1);
			delay = 3 + int'($unsigned($random(seed)) % 18);
			repeat (delay) @(posedge clk);
			#1;
			dio_ack = 1'b1;
			wait (br === 1'b0);
			@(posedge clk);
			#1;
			dio_ack = 1'b0;
		end
	end

	initial begin : watchdog
		#(watchdog_cycles * 10);
		$display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
		$display("Test FAILED");
		$finish;
	end

	initial begin : main
		int i;
		reset = 1'b1;
		din = '0;
		sel = 1'b0;
		addr = '0;
		uds = 1'b1;
		lds = 1'b1;
		rw = 1'b1;
		fdc_wr_prot = 1'b0;
		// only target 1 answers
		acsi_enable = 8'h02;
		dio_idx = '0;
		drv_side = 1'b1;
		drv_sel = 2'b01;
		parm_bytes = '{8'h0a, 8'h1b, 8'h2c, 8'h01, 8'h3d};
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// register read-back, cpu side and status port
		bus_write(addr_base_hi, 16'h0012);
		bus_write(addr_base_mid, 16'h0034);
		bus_write(addr_base_lo, 16'h0056);
		bus_read(addr_base_hi, rd);
		expect_eq(rd, 16'h0012, "base high byte");
		bus_read(addr_base_mid, rd);
		expect_eq(rd, 16'h0034, "base middle byte");
		bus_read(addr_base_lo, rd);
		expect_eq(rd, 16'h0056, "base low byte");
		check_dio(5'd0, 8'h12, "status port base high");
		check_dio(5'd1, 8'h34, "status port base middle");
		check_dio(5'd2, 8'h56, "status port base low");
		write_reg(mode_scnt_sel, 8'h05);
		bus_read(addr_ctrl, rd);
		expect_eq(rd, 16'h0005, "sector count");
		check_dio(5'd3, 8'h05, "status port sector count");
		bus_read(addr_status, rd);
		expect_eq(rd, 16'h0003, "dma status with sectors pending");
		write_reg(mode_track, 8'h21);
		bus_read(addr_ctrl, rd);
		expect_eq(rd, 16'h0021, "track register");
		check_dio(5'd5, 8'h21, "status port track");
		write_reg(mode_sector, 8'h09);
		bus_read(addr_ctrl, rd);
		expect_eq(rd, 16'h0009, "sector register");
		check_dio(5'd6, 8'h09, "status port sector");
		write_reg(mode_data, 8'h07);
		bus_read(addr_ctrl, rd);
		expect_eq(rd, 16'h0007, "data register");
		check_dio(5'd7, 8'h07, "status port data");

		// type I, seek target is the data register
		bus_write(addr_status, mode_fdc_cmd);
		type1_command(8'h00, 8'h00, "restore");
		type1_command(8'h10, 8'h07, "seek");
		type1_command(8'h50, 8'h08, "step in");
		type1_command(8'h30, 8'h09, "step");
		type1_command(8'h70, 8'h08, "step out");

		// motor timer, restore reloads 40 ticks at the write edge
		bus_write(addr_ctrl, 16'h0000);
		repeat (38) @(posedge clk);
		#1;
		sel = 1'b1;
		rw = 1'b1;
		lds = 1'b0;
		addr = addr_ctrl;
		#2;
		expect_bit(dout[7], 1'b1, "motor running 38 cycles after command");
		@(posedge clk);
		#3;
		expect_bit(dout[7], 1'b1, "motor running 39 cycles after command");
		@(posedge clk);
		#3;
		expect_bit(dout[7], 1'b0, "motor stopped 40 cycles after command");
		@(posedge clk);
		#1;
		sel = 1'b0;
		lds = 1'b1;

		// read sector, waits for the I/O controller
		write_reg(mode_scnt_sel, 8'h02);
		bus_write(addr_status, mode_fdc_cmd);
		bus_write(addr_ctrl, 16'h0080);
		expect_bit(br, 1'b1, "br after read sector");
		bus_read(addr_ctrl, rd);
		expect_eq(rd, 16'h0081, "status while read sector waits");
		dio_idx = 5'd3;
		wait_ack(40, "read sector");
		@(posedge clk);
		#1;
		expect_bit(br, 1'b1, "br one cycle after ack");
		@(posedge clk);
		#1;
		expect_bit(br, 1'b0, "br two cycles after ack");
		expect_eq({8'h00, dio_data}, 16'h0000, "sector count cleared by ack");
		expect_bit(irq, 1'b0, "read sector irq too early");
		@(posedge clk);
		#1;
		expect_bit(irq, 1'b1, "read sector irq");
		bus_read(addr_ctrl, rd);
		expect_bit(rd[0], 1'b0, "busy after read sector");
		expect_bit(irq, 1'b0, "read sector irq cleared");
		bus_read(addr_status, rd);
		expect_eq(rd, 16'h0001, "dma status without sectors");

		// write sector on a protected disk, then force interrupt
		fdc_wr_prot = 1'b1;
		wp_phase = 1'b1;
		bus_write(addr_ctrl, 16'h00A0);
		expect_irq_after(2, "protected write sector");
		bus_read(addr_ctrl, rd);
		expect_eq(rd, 16'h00C0, "status after protected write sector");
		bus_write(addr_ctrl, 16'h00D0);
		expect_irq_after(1, "force interrupt");
		bus_read(addr_ctrl, rd);
		expect_eq(rd, 16'h00C0, "status after force interrupt");
		wp_phase = 1'b0;
		fdc_wr_prot = 1'b0;

		// acsi, target 1 opcode 08
		bus_write(addr_status, mode_acsi_first);
		bus_write(addr_ctrl, 16'h0028);
		expect_bit(irq, 1'b1, "acsi command byte irq");
		bus_read(addr_ctrl, rd);
		expect_eq(rd, 16'h0020, "acsi status target");
		expect_bit(irq, 1'b0, "acsi irq cleared");
		bus_write(addr_status, mode_acsi_parm);
		for (i = 0; i < 4; i++) begin
			bus_write(addr_ctrl, {8'h00, parm_bytes[i]});
			expect_bit(irq, 1'b1, "acsi parameter irq");
			bus_read(addr_ctrl, rd);
			expect_bit(irq, 1'b0, "acsi parameter irq cleared");
		end
		bus_write(addr_ctrl, {8'h00, parm_bytes[4]});
		expect_bit(br, 1'b1, "br on last acsi parameter");
		expect_bit(irq, 1'b0, "acsi irq before ack");
		check_dio(5'd8, {3'b000, 1'b1, drv_sel, drv_side, 1'b0}, "drive and busy byte");
		wait_ack(40, "acsi command");
		@(posedge clk);
		#1;
		expect_bit(irq, 1'b0, "acsi irq one cycle after ack");
		@(posedge clk);
		#1;
		expect_bit(irq, 1'b1, "acsi irq after ack");
		expect_bit(br, 1'b0, "br released after acsi ack");
		check_dio(5'd9, 8'h28, "status port target and command");
		for (i = 0; i < 5; i++)
			check_dio(5'(10 + i), parm_bytes[i], "status port acsi parameter");
		bus_read(addr_ctrl, rd);
		expect_bit(irq, 1'b0, "acsi irq cleared after command");

		// target 3 is disabled
		off_target_phase = 1'b1;
		bus_write(addr_status, mode_acsi_first);
		bus_write(addr_ctrl, 16'h0068);
		bus_write(addr_status, mode_acsi_parm);
		bus_write(addr_ctrl, 16'h0011);
		repeat (3) @(posedge clk);
		#1;
		off_target_phase = 1'b0;
		expect_bit(irq, 1'b0, "irq from disabled target");

		$display("checks %0d, errors %0d, property errors %0d", checks, errors, prop_errors);
		if (errors == 0 && prop_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: files.f
hdl/dma_pkg.sv
hdl/dma_regs.sv
hdl/fdc_emu.sv
hdl/acsi_cmd.sv
hdl/io_status.sv
hdl/dma_top.sv
tb/tb_dma.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_dma
FILELIST = files.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
